// ==== im2col_spc.f ====
+incdir+verilog
verilog/im2col_pkg.sv
verilog/dma_reg_pkg.sv
verilog/im2col_desc_gen.sv
verilog/im2col_desc_fifo.sv
verilog/im2col_dma_loader.sv
verilog/im2col_spc.sv
tests/im2col_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the im2col sequencer regression with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --top-module im2col_tb -f im2col_spc.f -o im2col_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/im2col_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Regression passed" "$LOG"; then
  exit 0
fi
exit 1

// ==== tests/im2col_tb.sv ====
`timescale 1ns/1ps
`include "im2col_cfg.svh"

module im2col_tb;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;
  localparam int RUN_TIMEOUT  = 4000;  // Longest run is 8 rows of 12 slow writes and a 30 cycle DMA
  localparam int WATCHDOG_CYCLES = 20000;  // All six runs together take well under 2000 cycles

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  logic                 start_i;
  im2col_pkg::run_cfg_t cfg_i;
  dma_reg_pkg::reg_wr_t reg_wr_o;
  logic                 reg_ack_i;
  logic                 dma_done_i;
  logic                 irq_en_i;
  logic                 irq_clear_i;
  logic                 ready_o;
  logic                 done_o;
  logic                 irq_o;

  string             test_name;
  im2col_pkg::addr_t exp_addr[$];
  im2col_pkg::addr_t exp_data[$];
  im2col_pkg::addr_t obs_addr[$];  // Every write the DMA model accepted, in order
  im2col_pkg::addr_t obs_data[$];
  int                done_count;
  int                launch_count;  // SIZE_D1 writes seen by the DMA model
  int                ack_min;
  int                ack_max;
  int                dma_min;
  int                dma_max;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  im2col_spc u_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start_i),
    .cfg_i       (cfg_i),
    .reg_wr_o    (reg_wr_o),
    .reg_ack_i   (reg_ack_i),
    .dma_done_i  (dma_done_i),
    .irq_en_i    (irq_en_i),
    .irq_clear_i (irq_clear_i),
    .ready_o     (ready_o),
    .done_o      (done_o),
    .irq_o       (irq_o)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_addr(input string what, input im2col_pkg::addr_t exp,
                            input im2col_pkg::addr_t act);
    if (act !== exp) begin
      abort_run($sformatf("[FAIL] %s: %s expected 0x%08h actual 0x%08h",
                          test_name, what, exp, act));
    end
  endtask

  task automatic check_count(input string what, input im2col_pkg::row_t exp,
                             input im2col_pkg::row_t act);
    if (act !== exp) begin
      abort_run($sformatf("[FAIL] %s: %s expected %0d actual %0d", test_name, what, exp, act));
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("[FAIL] %s: %s expected %b actual %b", test_name, what, exp, act));
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // DMA model: acknowledges writes after a random delay and times each transfer
  initial begin
    int   ack_wait;
    int   done_wait;
    logic ch_running;
    reg_ack_i    = 1'b0;
    dma_done_i   = 1'b0;
    done_count   = 0;
    launch_count = 0;
    ack_wait     = -1;
    done_wait    = 0;
    ch_running   = 1'b0;
    forever begin
      next_cycle();
      reg_ack_i  = 1'b0;
      dma_done_i = 1'b0;
      if (done_o) begin
        done_count++;
      end
      if (done_wait > 0) begin
        done_wait--;
        if (done_wait == 0) begin
          dma_done_i = 1'b1;
          ch_running = 1'b0;
        end
      end
      if (reg_wr_o.valid) begin
        if (ack_wait < 0) begin
          ack_wait = $urandom_range(ack_max, ack_min);
        end
        if (ack_wait == 0) begin
          if (ch_running) begin
            abort_run("Register write accepted while the previous DMA transfer was running");
          end
          reg_ack_i = 1'b1;
          obs_addr.push_back(reg_wr_o.addr);
          obs_data.push_back(reg_wr_o.wdata);
          if (reg_wr_o.addr == cfg_i.ch_offset + im2col_pkg::addr_t'(dma_reg_pkg::SIZE_D1)) begin
            ch_running = 1'b1;  // SIZE_D1 starts the transfer
            done_wait  = $urandom_range(dma_max, dma_min);
            launch_count++;
          end
          ack_wait = -1;
        end else begin
          ack_wait--;
        end
      end else begin
        ack_wait = -1;
      end
    end
  end

  function automatic void add_write(input im2col_pkg::run_cfg_t cfg,
                                    input dma_reg_pkg::dma_reg_e off,
                                    input im2col_pkg::addr_t data);
    exp_addr.push_back(cfg.ch_offset + im2col_pkg::addr_t'(off));
    exp_data.push_back(data);
  endfunction

  // Element size in bytes for the word, half and byte types
  function automatic im2col_pkg::addr_t elem_bytes(input im2col_pkg::dtype_t dtype);
    case (dtype)
      2'd0:    return 32'd4;
      2'd1:    return 32'd2;
      default: return 32'd1;
    endcase
  endfunction

  // Expected register writes of a whole run
  function automatic void build_expected(input im2col_pkg::run_cfg_t cfg);
    im2col_pkg::addr_t bytes;
    im2col_pkg::addr_t row;
    exp_addr.delete();
    exp_data.delete();
    bytes = elem_bytes(cfg.dtype);
    for (int k = 0; k < int'(cfg.num_rows); k++) begin
      row = im2col_pkg::addr_t'(k);
      if (k == 0) begin
        add_write(cfg, dma_reg_pkg::DIM, `IM2COL_DIM_2D);
        add_write(cfg, dma_reg_pkg::SLOT, {cfg.tx_slot, cfg.rx_slot});
        add_write(cfg, dma_reg_pkg::SRC_TYPE, im2col_pkg::addr_t'(cfg.dtype));
        add_write(cfg, dma_reg_pkg::DST_TYPE, im2col_pkg::addr_t'(cfg.dtype));
      end
      add_write(cfg, dma_reg_pkg::PAD_TOP, (k == 0) ? im2col_pkg::addr_t'(cfg.pad_top) : '0);
      add_write(cfg, dma_reg_pkg::PAD_BOTTOM,
                (k == int'(cfg.num_rows) - 1) ? im2col_pkg::addr_t'(cfg.pad_bottom) : '0);
      add_write(cfg, dma_reg_pkg::PAD_LEFT, im2col_pkg::addr_t'(cfg.pad_left));
      add_write(cfg, dma_reg_pkg::PAD_RIGHT, im2col_pkg::addr_t'(cfg.pad_right));
      add_write(cfg, dma_reg_pkg::SRC_PTR, cfg.src_base + row * cfg.src_row_step);
      add_write(cfg, dma_reg_pkg::DST_PTR, cfg.dst_base + row * cfg.dst_row_step);
      add_write(cfg, dma_reg_pkg::SRC_INC_D1, (32'd1 << cfg.log_stride_d1) * bytes);
      add_write(cfg, dma_reg_pkg::SRC_INC_D2, im2col_pkg::addr_t'(cfg.in_inc_d2) * bytes);
      add_write(cfg, dma_reg_pkg::DST_INC_D1, bytes);
      add_write(cfg, dma_reg_pkg::DST_INC_D2, bytes);
      add_write(cfg, dma_reg_pkg::SIZE_D2, im2col_pkg::addr_t'(cfg.size_d2));
      add_write(cfg, dma_reg_pkg::SIZE_D1, im2col_pkg::addr_t'(cfg.size_d1));
    end
  endfunction

  function automatic im2col_pkg::run_cfg_t make_cfg(input im2col_pkg::row_t rows,
                                                     input im2col_pkg::dtype_t dtype);
    im2col_pkg::run_cfg_t cfg;
    cfg.src_base      = 32'h1000_0000;
    cfg.dst_base      = 32'h2000_0400;
    cfg.src_row_step  = 32'h0000_0120;
    cfg.dst_row_step  = 32'h0000_0048;
    cfg.num_rows      = rows;
    cfg.pad_top       = 8'd2;
    cfg.pad_bottom    = 8'd3;
    cfg.pad_left      = 8'd1;
    cfg.pad_right     = 8'd4;
    cfg.size_d1       = 16'd9;
    cfg.size_d2       = 16'd3;
    cfg.log_stride_d1 = 4'd1;
    cfg.in_inc_d2     = 16'd34;
    cfg.dtype         = dtype;
    cfg.tx_slot       = 16'h0005;
    cfg.rx_slot       = 16'h000A;
    cfg.ch_offset     = 32'h4000_0100;
    return cfg;
  endfunction

  // Starts one run, waits for done_o and compares the write list
  task automatic run_and_check(input im2col_pkg::run_cfg_t cfg, input logic irq_en);
    int obs_base;
    int done_base;
    int launch_base;
    int cycles;
    build_expected(cfg);
    obs_base    = obs_addr.size();
    done_base   = done_count;
    launch_base = launch_count;
    cfg_i       = cfg;
    irq_en_i    = irq_en;
    start_i     = 1'b1;
    next_cycle();
    start_i = 1'b0;
    check_bit("ready_o while busy", 1'b0, ready_o);
    cycles = 0;
    while (done_o !== 1'b1) begin
      next_cycle();
      cycles++;
      if (cycles > RUN_TIMEOUT) begin
        abort_run($sformatf("done_o did not pulse within %0d cycles in %s", RUN_TIMEOUT,
                            test_name));
      end
    end
    check_bit("ready_o at done", 1'b1, ready_o);
    repeat (4) next_cycle();
    check_count("done pulses", 8'd1, im2col_pkg::row_t'(done_count - done_base));
    check_count("transfers", cfg.num_rows, im2col_pkg::row_t'(launch_count - launch_base));
    check_addr("write count", im2col_pkg::addr_t'(exp_addr.size()),
               im2col_pkg::addr_t'(obs_addr.size() - obs_base));
    foreach (exp_addr[i]) begin
      check_addr($sformatf("address of write %0d", i), exp_addr[i], obs_addr[obs_base + i]);
      check_addr($sformatf("data of write %0d", i), exp_data[i], obs_data[obs_base + i]);
    end
  endtask

  task automatic test_reset();
    test_name = "reset";
    check_bit("ready_o", 1'b1, ready_o);
    check_bit("reg_wr_o.valid", 1'b0, reg_wr_o.valid);
    check_bit("done_o", 1'b0, done_o);
    check_bit("irq_o", 1'b0, irq_o);
  endtask

  task automatic test_single_row();
    im2col_pkg::run_cfg_t cfg;
    test_name = "single_row_word";
    run_and_check(make_cfg(8'd1, 2'd0), 1'b0);
    test_name = "single_row_byte";
    cfg = make_cfg(8'd1, 2'd2);
    cfg.log_stride_d1 = 4'd2;
    run_and_check(cfg, 1'b0);
  endtask

  task automatic test_five_rows();
    im2col_pkg::run_cfg_t cfg;
    test_name = "five_rows";
    cfg = make_cfg(8'd5, 2'd1);
    cfg.src_base = $urandom & 32'hFFFF_FFF0;
    cfg.dst_base = $urandom & 32'hFFFF_FFF0;
    run_and_check(cfg, 1'b0);
  endtask

  task automatic test_back_pressure();
    test_name = "back_pressure";
    ack_min = 2;
    ack_max = 6;
    dma_min = 12;
    dma_max = 30;
    run_and_check(make_cfg(8'd8, 2'd0), 1'b0);  // More rows than FIFO slots
    ack_min = 0;
    ack_max = 3;
    dma_min = 2;
    dma_max = 8;
  endtask

  task automatic test_completion();
    test_name = "irq_enabled";
    run_and_check(make_cfg(8'd2, 2'd2), 1'b1);
    check_bit("irq_o after done", 1'b1, irq_o);
    repeat (6) next_cycle();
    check_bit("irq_o held", 1'b1, irq_o);
    irq_clear_i = 1'b1;
    next_cycle();
    irq_clear_i = 1'b0;
    check_bit("irq_o after clear", 1'b0, irq_o);
    test_name = "irq_disabled";
    run_and_check(make_cfg(8'd2, 2'd1), 1'b0);
    check_bit("irq_o without enable", 1'b0, irq_o);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run($sformatf("Watchdog expired after %0d cycles without the tests finishing",
                        WATCHDOG_CYCLES));
  end

  initial begin
    void'($urandom(89));
    rst_ni      = 1'b0;
    start_i     = 1'b0;
    cfg_i       = '0;
    irq_en_i    = 1'b0;
    irq_clear_i = 1'b0;
    ack_min     = 0;
    ack_max     = 3;
    dma_min     = 2;  // One cycle less would let the done pulse collide with LAUNCH
    dma_max     = 8;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    test_reset();
    test_single_row();
    test_five_rows();
    test_back_pressure();
    test_completion();
    $display("Regression passed");
    $finish;
  end

endmodule

// ==== verilog/im2col_spc.sv ====
`timescale 1ns/1ps

module im2col_spc (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  im2col_pkg::run_cfg_t cfg_i,
  output dma_reg_pkg::reg_wr_t reg_wr_o,
  input  logic                 reg_ack_i,
  input  logic                 dma_done_i,
  input  logic                 irq_en_i,
  input  logic                 irq_clear_i,
  output logic                 ready_o,
  output logic                 done_o,
  output logic                 irq_o
);

  im2col_pkg::desc_t       gen_desc;
  im2col_pkg::desc_t       fifo_desc;
  im2col_pkg::run_status_e status_q;
  logic                    gen_push;
  logic                    gen_done;
  logic                    fifo_full;
  logic                    fifo_empty;
  logic                    fifo_pop;
  logic                    launch;
  logic                    loader_idle;
  logic                    ch_busy_q;
  logic                    run_end;
  logic                    done_q;
  logic                    irq_q;

  im2col_desc_gen u_desc_gen (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start_i),
    .cfg_i       (cfg_i),
    .fifo_full_i (fifo_full),
    .push_o      (gen_push),
    .desc_o      (gen_desc),
    .gen_done_o  (gen_done)
  );

  im2col_desc_fifo u_desc_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (gen_push),
    .desc_i  (gen_desc),
    .pop_i   (fifo_pop),
    .desc_o  (fifo_desc),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  im2col_dma_loader u_dma_loader (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_i),
    .cfg_i        (cfg_i),
    .desc_i       (fifo_desc),
    .fifo_empty_i (fifo_empty),
    .ch_free_i    (~ch_busy_q),
    .reg_ack_i    (reg_ack_i),
    .reg_wr_o     (reg_wr_o),
    .pop_o        (fifo_pop),
    .launch_o     (launch),
    .idle_o       (loader_idle)
  );

  // Everything has drained and the last transfer has finished
  assign run_end = (status_q == im2col_pkg::BUSY) & gen_done & fifo_empty & loader_idle &
                   ~ch_busy_q;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      ch_busy_q <= 1'b0;
      status_q  <= im2col_pkg::READY;
      done_q    <= 1'b0;
      irq_q     <= 1'b0;
    end else begin
      if (launch) begin
        ch_busy_q <= 1'b1;  // SIZE_D1 was just written, the transfer is running
      end else if (dma_done_i) begin
        ch_busy_q <= 1'b0;
      end
      if (run_end) begin
        status_q <= im2col_pkg::READY;
      end else if (start_i) begin
        status_q <= im2col_pkg::BUSY;
      end
      done_q <= run_end;  // Status leaves BUSY at the same edge, so this lasts one cycle
      if (run_end && irq_en_i) begin
        irq_q <= 1'b1;
      end else if (irq_clear_i) begin
        irq_q <= 1'b0;
      end
    end
  end

  assign ready_o = (status_q == im2col_pkg::READY);
  assign done_o  = done_q;
  assign irq_o   = irq_q;

endmodule

// ==== verilog/im2col_dma_loader.sv ====
`timescale 1ns/1ps
`include "im2col_cfg.svh"

module im2col_dma_loader (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  start_i,
  input  im2col_pkg::run_cfg_t  cfg_i,
  input  im2col_pkg::desc_t     desc_i,
  input  logic                  fifo_empty_i,
  input  logic                  ch_free_i,
  input  logic                  reg_ack_i,
  output dma_reg_pkg::reg_wr_t  reg_wr_o,
  output logic                  pop_o,
  output logic                  launch_o,
  output logic                  idle_o
);

  im2col_pkg::load_state_e state_q;
  im2col_pkg::load_state_e state_d;
  logic                    first_done_q;  // Shared registers already hold this run's values
  dma_reg_pkg::dma_reg_e   wr_off;
  im2col_pkg::addr_t       wr_data;
  im2col_pkg::dtype_t      elem_shift;

  assign elem_shift = im2col_pkg::dtype_t'(2) - cfg_i.dtype;  // Elements to bytes
  assign idle_o     = (state_q == im2col_pkg::IDLE);
  assign launch_o   = (state_q == im2col_pkg::LAUNCH);
  assign pop_o      = launch_o;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      im2col_pkg::IDLE: begin
        if (!fifo_empty_i && ch_free_i) begin
          state_d = first_done_q ? im2col_pkg::WRITE_PAD_TOP : im2col_pkg::WRITE_DIM;
        end
      end
      im2col_pkg::LAUNCH: begin
        state_d = im2col_pkg::IDLE;
      end
      default: begin
        if (reg_ack_i) begin
          state_d = im2col_pkg::load_state_e'(state_q + 5'd1);  // Next register in map order
        end
      end
    endcase
  end

  always_comb begin
    wr_off = dma_reg_pkg::DIM;
    unique case (state_q)
      im2col_pkg::WRITE_SLOT:       wr_off = dma_reg_pkg::SLOT;
      im2col_pkg::WRITE_SRC_TYPE:   wr_off = dma_reg_pkg::SRC_TYPE;
      im2col_pkg::WRITE_DST_TYPE:   wr_off = dma_reg_pkg::DST_TYPE;
      im2col_pkg::WRITE_PAD_TOP:    wr_off = dma_reg_pkg::PAD_TOP;
      im2col_pkg::WRITE_PAD_BOTTOM: wr_off = dma_reg_pkg::PAD_BOTTOM;
      im2col_pkg::WRITE_PAD_LEFT:   wr_off = dma_reg_pkg::PAD_LEFT;
      im2col_pkg::WRITE_PAD_RIGHT:  wr_off = dma_reg_pkg::PAD_RIGHT;
      im2col_pkg::WRITE_SRC_PTR:    wr_off = dma_reg_pkg::SRC_PTR;
      im2col_pkg::WRITE_DST_PTR:    wr_off = dma_reg_pkg::DST_PTR;
      im2col_pkg::WRITE_SRC_INC_D1: wr_off = dma_reg_pkg::SRC_INC_D1;
      im2col_pkg::WRITE_SRC_INC_D2: wr_off = dma_reg_pkg::SRC_INC_D2;
      im2col_pkg::WRITE_DST_INC_D1: wr_off = dma_reg_pkg::DST_INC_D1;
      im2col_pkg::WRITE_DST_INC_D2: wr_off = dma_reg_pkg::DST_INC_D2;
      im2col_pkg::WRITE_SIZE_D2:    wr_off = dma_reg_pkg::SIZE_D2;
      im2col_pkg::WRITE_SIZE_D1:    wr_off = dma_reg_pkg::SIZE_D1;
      default:                      wr_off = dma_reg_pkg::DIM;
    endcase
  end

  always_comb begin
    wr_data = '0;
    unique case (state_q)
      im2col_pkg::WRITE_DIM:        wr_data = im2col_pkg::addr_t'(`IM2COL_DIM_2D);
      im2col_pkg::WRITE_SLOT:       wr_data = im2col_pkg::addr_t'({cfg_i.tx_slot, cfg_i.rx_slot});
      im2col_pkg::WRITE_SRC_TYPE:   wr_data = im2col_pkg::addr_t'(cfg_i.dtype);
      im2col_pkg::WRITE_DST_TYPE:   wr_data = im2col_pkg::addr_t'(cfg_i.dtype);
      im2col_pkg::WRITE_PAD_TOP:    wr_data = im2col_pkg::addr_t'(desc_i.pad_top);
      im2col_pkg::WRITE_PAD_BOTTOM: wr_data = im2col_pkg::addr_t'(desc_i.pad_bottom);
      im2col_pkg::WRITE_PAD_LEFT:   wr_data = im2col_pkg::addr_t'(desc_i.pad_left);
      im2col_pkg::WRITE_PAD_RIGHT:  wr_data = im2col_pkg::addr_t'(desc_i.pad_right);
      im2col_pkg::WRITE_SRC_PTR:    wr_data = desc_i.input_ptr;
      im2col_pkg::WRITE_DST_PTR:    wr_data = desc_i.output_ptr;
      im2col_pkg::WRITE_SRC_INC_D1: begin
        wr_data = (im2col_pkg::addr_t'(1) << cfg_i.log_stride_d1) << elem_shift;
      end
      im2col_pkg::WRITE_SRC_INC_D2: begin
        wr_data = im2col_pkg::addr_t'(desc_i.in_inc_d2) << elem_shift;
      end
      im2col_pkg::WRITE_DST_INC_D1: wr_data = im2col_pkg::addr_t'(4) >> cfg_i.dtype;  // Dense output
      im2col_pkg::WRITE_DST_INC_D2: wr_data = im2col_pkg::addr_t'(4) >> cfg_i.dtype;
      im2col_pkg::WRITE_SIZE_D2:    wr_data = im2col_pkg::addr_t'(desc_i.size_d2);
      im2col_pkg::WRITE_SIZE_D1:    wr_data = im2col_pkg::addr_t'(desc_i.size_d1);
      default:                      wr_data = '0;
    endcase
  end

  assign reg_wr_o.valid = ~idle_o & ~launch_o;
  assign reg_wr_o.addr  = cfg_i.ch_offset + im2col_pkg::addr_t'(wr_off);
  assign reg_wr_o.wdata = wr_data;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= im2col_pkg::IDLE;
      first_done_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (start_i) begin
        first_done_q <= 1'b0;  // A new run rewrites the full register set
      end else if (launch_o) begin
        first_done_q <= 1'b1;
      end
    end
  end

endmodule

// ==== verilog/im2col_desc_fifo.sv ====
`timescale 1ns/1ps
`include "im2col_cfg.svh"

module im2col_desc_fifo (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              push_i,
  input  im2col_pkg::desc_t desc_i,
  input  logic              pop_i,
  output im2col_pkg::desc_t desc_o,
  output logic              full_o,
  output logic              empty_o
);

  localparam int unsigned DEPTH = `IM2COL_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  im2col_pkg::desc_t mem_q [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              do_push;
  logic              do_pop;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign desc_o  = mem_q[rd_ptr_q];  // Registered storage, no fall-through

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      if (do_push != do_pop) begin
        count_q <= do_push ? count_q + CNT_W'(1) : count_q - CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= desc_i;
    end
  end

endmodule

// ==== verilog/im2col_desc_gen.sv ====
`timescale 1ns/1ps

module im2col_desc_gen (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  im2col_pkg::run_cfg_t cfg_i,
  input  logic                 fifo_full_i,
  output logic                 push_o,
  output im2col_pkg::desc_t    desc_o,
  output logic                 gen_done_o
);

  im2col_pkg::row_t  row_q;
  im2col_pkg::row_t  last_row;
  im2col_pkg::addr_t src_ptr_q;
  im2col_pkg::addr_t dst_ptr_q;
  logic              active_q;

  assign last_row   = cfg_i.num_rows - im2col_pkg::row_t'(1);
  assign push_o     = active_q & ~fifo_full_i;  // Stall while the FIFO is full
  assign gen_done_o = ~active_q;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      row_q    <= '0;
    end else if (start_i) begin
      active_q <= (cfg_i.num_rows != '0);  // An empty run has nothing to push
      row_q    <= '0;
    end else if (push_o) begin
      active_q <= (row_q != last_row);
      row_q    <= row_q + im2col_pkg::row_t'(1);
    end
  end

  // Running pointers avoid a multiplier for row k
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      src_ptr_q <= cfg_i.src_base;
      dst_ptr_q <= cfg_i.dst_base;
    end else if (push_o) begin
      src_ptr_q <= src_ptr_q + cfg_i.src_row_step;
      dst_ptr_q <= dst_ptr_q + cfg_i.dst_row_step;
    end
  end

  always_comb begin
    desc_o.input_ptr  = src_ptr_q;
    desc_o.output_ptr = dst_ptr_q;
    desc_o.pad_top    = (row_q == '0) ? cfg_i.pad_top : '0;  // Top edge only
    desc_o.pad_bottom = (row_q == last_row) ? cfg_i.pad_bottom : '0;  // Bottom edge only
    desc_o.pad_left   = cfg_i.pad_left;
    desc_o.pad_right  = cfg_i.pad_right;
    desc_o.in_inc_d2  = cfg_i.in_inc_d2;
    desc_o.size_d1    = cfg_i.size_d1;
    desc_o.size_d2    = cfg_i.size_d2;
  end

endmodule

// ==== verilog/dma_reg_pkg.sv ====
`include "im2col_cfg.svh"

package dma_reg_pkg;

  typedef enum logic [`IM2COL_REG_OFF_W-1:0] {
    DIM        = 8'h00,
    SLOT       = 8'h04,  // Tx slot in the upper half, rx slot in the lower half
    SRC_TYPE   = 8'h08,
    DST_TYPE   = 8'h0C,
    PAD_TOP    = 8'h10,
    PAD_BOTTOM = 8'h14,
    PAD_LEFT   = 8'h18,
    PAD_RIGHT  = 8'h1C,
    SRC_PTR    = 8'h20,
    DST_PTR    = 8'h24,
    SRC_INC_D1 = 8'h28,
    SRC_INC_D2 = 8'h2C,
    DST_INC_D1 = 8'h30,
    DST_INC_D2 = 8'h34,
    SIZE_D2    = 8'h38,
    SIZE_D1    = 8'h3C  // Writing this register starts the transfer
  } dma_reg_e;

  typedef struct packed {
    logic                      valid;  // Held until the DMA acknowledges
    logic [`IM2COL_ADDR_W-1:0] addr;
    logic [`IM2COL_ADDR_W-1:0] wdata;
  } reg_wr_t;

endpackage

// ==== verilog/im2col_pkg.sv ====
`include "im2col_cfg.svh"

package im2col_pkg;

  typedef logic [`IM2COL_ADDR_W-1:0] addr_t;  // Byte address or full register value
  typedef logic [`IM2COL_PAD_W-1:0] pad_t;
  typedef logic [`IM2COL_SIZE_W-1:0] size_t;
  typedef logic [`IM2COL_ROW_W-1:0] row_t;
  typedef logic [`IM2COL_SLOT_W-1:0] slot_t;
  typedef logic [`IM2COL_LOG_STRIDE_W-1:0] log_stride_t;
  typedef logic [`IM2COL_DTYPE_W-1:0] dtype_t;  // 0 word, 1 half, 2 byte

  typedef struct packed {
    addr_t       src_base;
    addr_t       dst_base;
    addr_t       src_row_step;  // Source bytes between two output rows
    addr_t       dst_row_step;
    row_t        num_rows;
    pad_t        pad_top;
    pad_t        pad_bottom;
    pad_t        pad_left;
    pad_t        pad_right;
    size_t       size_d1;
    size_t       size_d2;
    log_stride_t log_stride_d1;
    size_t       in_inc_d2;  // In elements, the loader scales it to bytes
    dtype_t      dtype;
    slot_t       tx_slot;
    slot_t       rx_slot;
    addr_t       ch_offset;  // Base address of the DMA channel
  } run_cfg_t;

  typedef struct packed {
    addr_t input_ptr;
    addr_t output_ptr;
    pad_t  pad_top;
    pad_t  pad_bottom;
    pad_t  pad_left;
    pad_t  pad_right;
    size_t in_inc_d2;
    size_t size_d1;
    size_t size_d2;
  } desc_t;

  typedef enum logic {
    READY,
    BUSY
  } run_status_e;

  // The WRITE_ states follow the DMA register map, so the loader steps through them in order
  typedef enum logic [4:0] {
    IDLE,
    WRITE_DIM,
    WRITE_SLOT,
    WRITE_SRC_TYPE,
    WRITE_DST_TYPE,
    WRITE_PAD_TOP,
    WRITE_PAD_BOTTOM,
    WRITE_PAD_LEFT,
    WRITE_PAD_RIGHT,
    WRITE_SRC_PTR,
    WRITE_DST_PTR,
    WRITE_SRC_INC_D1,
    WRITE_SRC_INC_D2,
    WRITE_DST_INC_D1,
    WRITE_DST_INC_D2,
    WRITE_SIZE_D2,
    WRITE_SIZE_D1,
    LAUNCH
  } load_state_e;

endpackage

// ==== verilog/im2col_cfg.svh ====
`ifndef IM2COL_CFG_SVH
`define IM2COL_CFG_SVH

`define IM2COL_FIFO_DEPTH 4  // Pending descriptors between generator and loader

`define IM2COL_ADDR_W 32  // Byte addresses, pointers and DMA register data
`define IM2COL_PAD_W 8  // Zero padding count per side
`define IM2COL_SIZE_W 16  // DMA transfer size per dimension
`define IM2COL_ROW_W 8  // Output row counter
`define IM2COL_SLOT_W 16  // One trigger slot field, the register packs two
`define IM2COL_LOG_STRIDE_W 4  // Log2 of the horizontal stride
`define IM2COL_DTYPE_W 2  // Element type code

`define IM2COL_REG_OFF_W 8  // Width of a DMA register offset
`define IM2COL_DIM_2D 1  // Dimensionality register value for 2D transfers

`endif
